// File: Bender.yml
package:
  name: n64Vid

sources:
  - include_dirs:
      - include
    files:
      - source/n64VidPkg.sv
      - source/vidPixelIf.sv
      - source/vidDemux.sv
      - source/colorChannel.sv
      - source/pixelPacker.sv
      - source/n64VidTop.sv
  - target: test
    files:
      - tb/n64VidTb.sv

// File: include/n64VidSyncBits.svh
// N64 video sync word flags
// Bit positions of the active-low flags in the low nibble of a sync word
`ifndef N64VID_SYNC_BITS_SVH
`define N64VID_SYNC_BITS_SVH

// Vertical sync
`define vSyncBit 3
// Clamp, low during blanking
`define clampBit 2
// Horizontal sync
`define hSyncBit 1
// Composite sync
`define cSyncBit 0

`endif

// File: n64Vid.f
+incdir+include
source/n64VidPkg.sv
source/vidPixelIf.sv
source/vidDemux.sv
source/colorChannel.sv
source/pixelPacker.sv
source/n64VidTop.sv
tb/n64VidTb.sv

// File: source/colorChannel.sv
// Color channel pipeline
// Expands one 7-bit component to 8 bits, then applies range scaling and blanking
`include "n64VidSyncBits.svh"

module colorChannel #(
  parameter int unsigned chanIdx = 0
) (
  input  logic                 SCLK_1,
  input  logic                 rstN_i,
  vidPixelIf.chanSide          pix_i,
  output n64VidPkg::colorOut_t chanOut_o
);
  import n64VidPkg::*;

  // Stage 1
  logic      s1Valid;
  colorOut_t s1Exp;
  logic      s1Lim;
  logic      s1ClampN;
  // Stage 2 state for the range check
  logic      s2Valid;
  logic      s2Lim;

  logic [2*coWidth-1:0] scaled;
  colorOut_t            limVal;

  ////////////////////////////////////////////////////////////////////
  // Stage 1: expansion
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge SCLK_1) begin
    if (!rstN_i) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= pix_i.pixValid;
    end
  end

  always_ff @(posedge SCLK_1) begin
    if (pix_i.pixValid) begin
      // MSB copied into new LSB, so 127 maps to 255
      s1Exp    <= {pix_i.color[chanIdx], pix_i.color[chanIdx][vdWidth-1]};
      s1Lim    <= pix_i.limRange;
      s1ClampN <= pix_i.syncN[`clampBit];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stage 2: range select and blanking
  ////////////////////////////////////////////////////////////////////

  // 16 + floor(exp * 219 / 256)
  assign scaled = s1Exp * limScaleMul;
  assign limVal = blackLimited + scaled[2*coWidth-1:coWidth];

  always_ff @(posedge SCLK_1) begin
    if (!rstN_i) begin
      s2Valid <= 1'b0;
    end else begin
      s2Valid <= s1Valid;
    end
  end

  always_ff @(posedge SCLK_1) begin
    if (s1Valid) begin
      s2Lim <= s1Lim;
      if (!s1ClampN) begin
        // Blanking, black of the active range
        chanOut_o <= s1Lim ? blackLimited : blackFull;
      end else begin
        chanOut_o <= s1Lim ? limVal : s1Exp;
      end
    end
  end

  // Limited range stays inside 16..235
  aLimRange: assert property (
    @(posedge SCLK_1) disable iff (!rstN_i)
    s2Valid && s2Lim |-> (chanOut_o >= blackLimited) &&
                         (chanOut_o <= blackLimited + limScaleMul)
  ) else $error("Channel %0d limited output %0d out of range", chanIdx, chanOut_o);

endmodule

// File: source/n64VidPkg.sv
// N64 video front end package
// Bus widths, component types, black levels and pipeline constants
package n64VidPkg;

  ////////////////////////////////////////////////////////////////////
  // Widths and types
  ////////////////////////////////////////////////////////////////////

  // Console video bus word
  localparam int unsigned vdWidth = 7;
  // Expanded component
  localparam int unsigned coWidth = 8;
  // Four active-low sync flags
  localparam int unsigned syncWidth = 4;

  // Red, green, blue
  localparam int unsigned numChannels = 3;

  typedef logic [vdWidth-1:0]   colorIn_t;
  typedef logic [coWidth-1:0]   colorOut_t;
  typedef logic [syncWidth-1:0] syncN_t;

  // Phase of the last word seen by the demux
  typedef enum logic [2:0] {
    phSync,
    phRed,
    phGreen,
    phBlue,
    phIdle
  } vidPhase_t;

  ////////////////////////////////////////////////////////////////////
  // Range scaling
  ////////////////////////////////////////////////////////////////////

  localparam colorOut_t blackFull    = 8'd0;
  localparam colorOut_t blackLimited = 8'd16;
  // 219/256 maps 0..255 onto 0..218, added to 16
  localparam colorOut_t limScaleMul  = 8'd219;

  // Register stages in each color channel
  localparam int unsigned chanLatency = 2;

endpackage

// File: source/n64VidTop.sv
// N64 video front end top level
// Demux, three color channels and output packer on SCLK_1
module n64VidTop (
  input  logic                 SCLK_1,
  input  logic                 rstN_i,
  // Console video bus
  input  logic                 nVDSYNC_i,
  input  n64VidPkg::colorIn_t  vd_i,
  // Range select, 1 for 16..235
  input  logic                 limRange_i,
  // Packed pixel out
  output logic                 pixValid_o,
  output n64VidPkg::syncN_t    syncN_o,
  output n64VidPkg::colorOut_t rOut_o,
  output n64VidPkg::colorOut_t gOut_o,
  output n64VidPkg::colorOut_t bOut_o
);
  import n64VidPkg::*;

  vidPixelIf pixBus ();

  colorOut_t chanOut [numChannels];

  vidDemux uDemux (
    .SCLK_1     (SCLK_1),
    .rstN_i     (rstN_i),
    .nVDSYNC_i  (nVDSYNC_i),
    .vd_i       (vd_i),
    .limRange_i (limRange_i),
    .pix_o      (pixBus.demuxSide)
  );

  // One channel per component, index selects R, G or B
  for (genvar ch = 0; ch < numChannels; ch++) begin : gChan
    colorChannel #(
      .chanIdx (ch)
    ) uChan (
      .SCLK_1    (SCLK_1),
      .rstN_i    (rstN_i),
      .pix_i     (pixBus.chanSide),
      .chanOut_o (chanOut[ch])
    );
  end

  pixelPacker uPacker (
    .SCLK_1     (SCLK_1),
    .rstN_i     (rstN_i),
    .pix_i      (pixBus.packerSide),
    .chanOut_i  (chanOut),
    .pixValid_o (pixValid_o),
    .syncN_o    (syncN_o),
    .rOut_o     (rOut_o),
    .gOut_o     (gOut_o),
    .bOut_o     (bOut_o)
  );

endmodule

// File: source/pixelPacker.sv
// Pixel output packer
// Aligns sync and strobe with the channel pipeline and registers the pixel
`include "n64VidSyncBits.svh"

module pixelPacker (
  input  logic                 SCLK_1,
  input  logic                 rstN_i,
  vidPixelIf.packerSide        pix_i,
  input  n64VidPkg::colorOut_t chanOut_i [n64VidPkg::numChannels],
  output logic                 pixValid_o,
  output n64VidPkg::syncN_t    syncN_o,
  output n64VidPkg::colorOut_t rOut_o,
  output n64VidPkg::colorOut_t gOut_o,
  output n64VidPkg::colorOut_t bOut_o
);
  import n64VidPkg::*;

  // Delay line matching the channel stages
  logic [chanLatency-1:0] validDly;
  syncN_t                 syncDly [chanLatency];

  always_ff @(posedge SCLK_1) begin
    if (!rstN_i) begin
      validDly <= '0;
    end else begin
      validDly <= {validDly[chanLatency-2:0], pix_i.pixValid};
    end
  end

  always_ff @(posedge SCLK_1) begin
    syncDly[0] <= pix_i.syncN;
    for (int i = 1; i < chanLatency; i++) begin
      syncDly[i] <= syncDly[i-1];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Output register, holds the last pixel between strobes
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge SCLK_1) begin
    if (!rstN_i) begin
      pixValid_o <= 1'b0;
      syncN_o    <= '1;
      rOut_o     <= '0;
      gOut_o     <= '0;
      bOut_o     <= '0;
    end else begin
      pixValid_o <= validDly[chanLatency-1];
      if (validDly[chanLatency-1]) begin
        syncN_o <= syncDly[chanLatency-1];
        rOut_o  <= chanOut_i[0];
        gOut_o  <= chanOut_i[1];
        bOut_o  <= chanOut_i[2];
      end
    end
  end

  // Pixels are spaced, so the strobe never repeats
  aOneShot: assert property (
    @(posedge SCLK_1) disable iff (!rstN_i)
    pixValid_o |=> !pixValid_o
  ) else $error("pixValid_o high in two consecutive cycles");

endmodule

// File: source/vidDemux.sv
// N64 video bus demux
// Follows the word phase after nVDSYNC and assembles sync, R, G, B into a pixel
`include "n64VidSyncBits.svh"

module vidDemux (
  input  logic                SCLK_1,
  input  logic                rstN_i,
  input  logic                nVDSYNC_i,
  input  n64VidPkg::colorIn_t vd_i,
  input  logic                limRange_i,
  vidPixelIf.demuxSide        pix_o
);
  import n64VidPkg::*;

  // Phase of the word registered last
  vidPhase_t phase;

  ////////////////////////////////////////////////////////////////////
  // Phase FSM, sync latch and pixel strobe
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge SCLK_1) begin
    if (!rstN_i) begin
      phase          <= phIdle;
      pix_o.pixValid <= 1'b0;
      pix_o.syncN    <= '1;
      pix_o.limRange <= 1'b0;
    end else begin
      // Strobe lasts one cycle
      pix_o.pixValid <= 1'b0;
      if (!nVDSYNC_i) begin
        // Sync word restarts the sequence from any phase
        phase                    <= phSync;
        pix_o.syncN[`vSyncBit]   <= vd_i[`vSyncBit];
        pix_o.syncN[`clampBit]   <= vd_i[`clampBit];
        pix_o.syncN[`hSyncBit]   <= vd_i[`hSyncBit];
        pix_o.syncN[`cSyncBit]   <= vd_i[`cSyncBit];
        // Range bit travels with its sync word
        pix_o.limRange           <= limRange_i;
      end else begin
        case (phase)
          phSync:  phase <= phRed;
          phRed:   phase <= phGreen;
          phGreen: begin
            // This word is blue, pixel done
            phase          <= phBlue;
            pix_o.pixValid <= 1'b1;
          end
          // Extra words until next sync
          default: phase <= phIdle;
        endcase
      end
    end
  end

  // Component latches, written in their own phase only
  always_ff @(posedge SCLK_1) begin
    if (nVDSYNC_i) begin
      case (phase)
        phSync:  pix_o.color[0] <= vd_i;
        phRed:   pix_o.color[1] <= vd_i;
        phGreen: pix_o.color[2] <= vd_i;
        default: ;
      endcase
    end
  end

  // Sync words never come back to back on the bus
  aSyncSpacing: assert property (
    @(posedge SCLK_1) disable iff (!rstN_i)
    !nVDSYNC_i |=> nVDSYNC_i
  ) else $error("nVDSYNC low in two consecutive cycles");

endmodule

// File: source/vidPixelIf.sv
// Demultiplexed pixel bundle
// Carries one pixel strobe from the demux to the color channels and packer
interface vidPixelIf;
  import n64VidPkg::*;

  // One-cycle strobe, pixel complete
  logic     pixValid;
  // Sync nibble of this pixel's sync word
  syncN_t   syncN;
  // High selects 16..235 output range
  logic     limRange;
  // Raw components, index 0 red, 1 green, 2 blue
  colorIn_t color [numChannels];

  modport demuxSide (
    output pixValid,
    output syncN,
    output limRange,
    output color
  );

  modport chanSide (
    input pixValid,
    input syncN,
    input limRange,
    input color
  );

  // Packer only needs timing and sync
  modport packerSide (
    input pixValid,
    input syncN
  );

endinterface

// File: tb/n64VidTb.sv
// N64 video front end testbench
// Replays the pixel trace through the DUT and checks every output pixel
module n64VidTb;
  timeunit 1ns;
  timeprecision 1ps;
  import n64VidPkg::*;

  // Cycles allowed for the last pixels to leave the pipeline
  localparam int unsigned drainLimit = 200;

  typedef struct packed {
    syncN_t    syncN;
    colorOut_t r;
    colorOut_t g;
    colorOut_t b;
  } expPix_t;

  logic      SCLK_1;
  logic      rstN_i;
  logic      nVDSYNC_i;
  colorIn_t  vd_i;
  logic      limRange_i;
  logic      pixValid_o;
  syncN_t    syncN_o;
  colorOut_t rOut_o;
  colorOut_t gOut_o;
  colorOut_t bOut_o;

  // Expected pixels in trace order
  expPix_t expQ [$];
  int      valueErrs = 0;
  int      streamErrs = 0;
  int      seenPix = 0;
  integer  seed = 83830;

  n64VidTop dut (
    .SCLK_1     (SCLK_1),
    .rstN_i     (rstN_i),
    .nVDSYNC_i  (nVDSYNC_i),
    .vd_i       (vd_i),
    .limRange_i (limRange_i),
    .pixValid_o (pixValid_o),
    .syncN_o    (syncN_o),
    .rOut_o     (rOut_o),
    .gOut_o     (gOut_o),
    .bOut_o     (bOut_o)
  );

  // 40 ns period
  initial begin
    SCLK_1 = 1'b0;
    forever #20 SCLK_1 = ~SCLK_1;
  end

  ////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////

  task automatic checkColor(input colorOut_t got, input colorOut_t want, input string what);
    if (got !== want) begin
      $display("[FAIL] %0t ns: %s is %02h, expected %02h", $time, what, got, want);
      valueErrs++;
    end
  endtask

  task automatic checkSync(input syncN_t got, input syncN_t want, input string what);
    if (got !== want) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, want);
      valueErrs++;
    end
  endtask

  task automatic checkFlag(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, want);
      valueErrs++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////////////////////////////////

  // Sync word, range bit goes along with it
  task automatic sendSync(input colorIn_t word, input logic lim);
    @(posedge SCLK_1);
    nVDSYNC_i  <= 1'b0;
    vd_i       <= word;
    limRange_i <= lim;
  endtask

  // Color or idle word
  task automatic sendWord(input colorIn_t word);
    @(posedge SCLK_1);
    nVDSYNC_i <= 1'b1;
    vd_i      <= word;
  endtask

  // Output monitor, sampled mid-cycle
  always @(negedge SCLK_1) begin : watchOutput
    expPix_t want;
    if (rstN_i === 1'b1 && pixValid_o === 1'b1) begin
      if (expQ.size() == 0) begin
        $display("Unexpected output pixel at %0t ns with no trace pixel left", $time);
        streamErrs++;
      end else begin
        want = expQ.pop_front();
        checkSync(syncN_o, want.syncN, $sformatf("pixel %0d syncN_o", seenPix));
        checkColor(rOut_o, want.r, $sformatf("pixel %0d rOut_o", seenPix));
        checkColor(gOut_o, want.g, $sformatf("pixel %0d gOut_o", seenPix));
        checkColor(bOut_o, want.b, $sformatf("pixel %0d bOut_o", seenPix));
        seenPix++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Reset, trace replay, drain and summary
  ////////////////////////////////////////////////////////////////////

  initial begin
    int      fd;
    int      rc;
    int      nFields;
    int      sync;
    int      r;
    int      g;
    int      b;
    int      lim;
    int      eSync;
    int      eR;
    int      eG;
    int      eB;
    int      idle;
    int      sent;
    int      waited;
    string   line;
    expPix_t want;

    nVDSYNC_i  = 1'b1;
    vd_i       = '0;
    limRange_i = 1'b0;
    rstN_i     = 1'b0;

    // Reset held over five rising edges
    repeat (4) begin
      @(posedge SCLK_1);
      @(negedge SCLK_1);
      checkFlag(pixValid_o, 1'b0, "pixValid_o in reset");
      checkSync(syncN_o, '1, "syncN_o in reset");
    end
    @(posedge SCLK_1);
    rstN_i <= 1'b1;
    @(negedge SCLK_1);
    checkFlag(pixValid_o, 1'b0, "pixValid_o after reset");
    checkSync(syncN_o, '1, "syncN_o after reset");

    fd = $fopen("tb/n64VidTrace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file tb/n64VidTrace.txt");
      streamErrs++;
    end else begin
      sent = 0;
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        // Skip comments and blank lines
        if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
          nFields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            sync, r, g, b, lim, eSync, eR, eG, eB);
          if (nFields != 9) begin
            $display("Trace line could not be parsed: %s", line);
            streamErrs++;
          end else begin
            want.syncN = syncN_t'(eSync);
            want.r     = colorOut_t'(eR);
            want.g     = colorOut_t'(eG);
            want.b     = colorOut_t'(eB);
            expQ.push_back(want);
            sendSync(colorIn_t'(sync), lim[0]);
            sendWord(colorIn_t'(r));
            sendWord(colorIn_t'(g));
            sendWord(colorIn_t'(b));
            // First pixels back to back, then 0..3 random idle words
            idle = (sent < 6) ? 0 : int'($unsigned($random(seed)) % 4);
            repeat (idle) sendWord(colorIn_t'($random(seed)));
            sent++;
          end
        end
      end
      $fclose(fd);

      waited = 0;
      while (expQ.size() != 0 && waited < drainLimit) begin
        @(posedge SCLK_1);
        waited++;
      end
      if (expQ.size() != 0) begin
        $display("Timed out after %0d cycles: %0d trace pixels never appeared",
                 drainLimit, expQ.size());
        streamErrs += expQ.size();
      end
      // A few more cycles to catch a stray strobe
      repeat (8) @(posedge SCLK_1);
    end

    $display("Summary: %0d pixels checked, %0d value errors, %0d stream errors",
             seenPix, valueErrs, streamErrs);
    if (valueErrs == 0 && streamErrs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: tb/n64VidTrace.txt
# Columns (hex): sync nibble, raw R, raw G, raw B, limited range (1 = 16..235),
# expected syncN, expected 8-bit R, G, B
F 7F 7F 7F 0 F FF FF FF
F 00 00 00 0 F 00 00 00
F 40 3F 01 0 F 81 7E 02
F 10 20 55 0 F 20 40 AB
F 2A 7E 60 0 F 54 FD C1
F 7F 00 40 1 F EA 10 7E
F 3F 01 10 1 F 7B 11 2B
F 20 55 2A 1 F 46 A2 57
F 7E 60 05 1 F E8 B5 18
F 33 4C 19 1 F 67 92 3A
F 71 7F 00 1 F D2 EA 10
B 7F 55 33 0 B 00 00 00
8 60 10 7E 0 8 00 00 00
B 7F 7F 7F 1 B 10 10 10
3 2A 05 71 1 3 10 10 10
C 05 33 4C 0 C 0A 66 99
6 19 71 2A 0 6 32 E3 54
7 4C 19 05 1 7 92 3A 18
D 60 2A 3F 1 D B5 57 7B
E 01 40 20 0 E 02 81 40
5 55 7E 10 0 5 AB FD 20
0 7F 7F 7F 0 0 00 00 00
9 00 7F 40 1 9 10 10 10
4 33 00 7F 1 4 67 10 EA
F 71 4C 55 0 F E3 99 AB
F 05 19 3F 1 F 18 3A 7B
